//--- verilog/ads5296_pkg.sv
package ads5296_pkg;

  // word addresses, decoded from wb_adr_i[6:2]
  localparam logic [4:0] REG_DLY_LOAD_LO = 5'd0;   // load strobe for the data lanes
  localparam logic [4:0] REG_DLY_LOAD_HI = 5'd1;   // load strobe for fclk and sync lanes
  localparam logic [4:0] REG_DLY_RST_LO  = 5'd2;
  localparam logic [4:0] REG_DLY_RST_HI  = 5'd3;
  localparam logic [4:0] REG_DLY_VTC_LO  = 5'd4;
  localparam logic [4:0] REG_DLY_VTC_HI  = 5'd5;
  localparam logic [4:0] REG_DLY_VAL     = 5'd6;   // tap value plus busy flag at bit 16
  localparam logic [4:0] REG_FCLK_ERR    = 5'd7;   // read only
  localparam logic [4:0] REG_ISERDES_RST = 5'd8;
  localparam logic [4:0] REG_MMCM_CTRL   = 5'd9;   // rst in bit 0 and clksel in bit 8
  localparam logic [4:0] REG_LCLK_CNT    = 5'd10;  // 10..14 read only rates
  localparam logic [4:0] REG_FCLK0_CNT   = 5'd11;
  localparam logic [4:0] REG_FCLK1_CNT   = 5'd12;
  localparam logic [4:0] REG_FCLK2_CNT   = 5'd13;
  localparam logic [4:0] REG_FCLK3_CNT   = 5'd14;
  localparam logic [4:0] REG_BITSLIP     = 5'd15;
  localparam logic [4:0] REG_SNAPSHOT    = 5'd16;
  localparam logic [4:0] REG_VERSION     = 5'd17;  // read only
  localparam logic [4:0] REG_SLIP_IDX    = 5'd18;
  localparam logic [4:0] REG_LAST        = REG_SLIP_IDX;  // above this is unmapped

  // ideal frame clock word, 8x serialization
  localparam logic [7:0] FRAME_PATTERN = 8'hF0;

  localparam int DELAY_W = 9;  // idelay tap count

  // 8 data lanes per adc, one per frame clock, plus the sync lane
  function automatic int num_lanes(input int units, input int fclks);
    return 8 * units + fclks + 1;
  endfunction

endpackage

//--- verilog/wb_ads5296_attach.sv
module wb_ads5296_attach
  import ads5296_pkg::*;
#(
  parameter int G_NUM_UNITS = 4,
  parameter int G_NUM_FCLKS = 1,
  parameter int G_IS_MASTER = 0,
  parameter int G_VERSION   = 0
) (
  input  logic                                          wb_clk_i,
  input  logic                                          wb_rst_i,
  input  logic [31:0]                                   wb_adr_i,
  input  logic [31:0]                                   wb_dat_i,
  input  logic [3:0]                                    wb_sel_i,
  input  logic                                          wb_we_i,
  input  logic                                          wb_cyc_i,
  input  logic                                          wb_stb_i,
  output logic [31:0]                                   wb_dat_o,
  output logic                                          wb_ack_o,
  output logic                                          wb_err_o,
  input  logic                                          mmcm_locked_i,
  input  logic                                          seq_busy_i,
  input  logic [31:0]                                   err_cnt_i,
  input  logic [31:0]                                   lclk_cnt_i,
  input  logic [31:0]                                   fclk0_cnt_i,
  input  logic [31:0]                                   fclk1_cnt_i,
  input  logic [31:0]                                   fclk2_cnt_i,
  input  logic [31:0]                                   fclk3_cnt_i,
  output logic                                          load_req_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] load_mask_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] vtc_reg_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_rst_o,
  output logic [DELAY_W-1:0]                            delay_val_o,
  output logic [4*G_NUM_UNITS-1:0]                      bitslip_o,
  output logic [2:0]                                    slip_index_o,
  output logic                                          iserdes_rst_o,
  output logic                                          mmcm_rst_o,
  output logic                                          mmcm_clksel_o,
  output logic                                          snapshot_trigger_o
);

  localparam int NL   = num_lanes(G_NUM_UNITS, G_NUM_FCLKS);
  localparam int LO_W = 8 * G_NUM_UNITS;  // lanes in the _LO words
  localparam int HI_W = NL - LO_W;        // fclk lanes + sync lane

  logic [NL-1:0] load_q;   // last value written to words 0/1, readback only
  logic [31:0]   rd_mux;
  logic [31:0]   rd_q;
  logic [31:0]   bmask;
  logic [31:0]   wdat;
  logic [4:0]    adr;
  logic          req;
  logic          is_load;
  logic          bad;

  assign adr     = wb_adr_i[6:2];
  assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;  // new request only
  assign is_load = (adr == REG_DLY_LOAD_LO) | (adr == REG_DLY_LOAD_HI);
  // unmapped word, or a load while the sequencer still runs
  assign bad     = (adr > REG_LAST) | (wb_we_i & is_load & (seq_busy_i | load_req_o));

  // byte lanes not selected keep the current contents
  assign bmask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
  assign wdat  = (wb_dat_i & bmask) | (rd_mux & ~bmask);

  assign wb_dat_o = wb_ack_o ? rd_q : 32'd0;  // data only alongside ack

  // current value of the addressed word, zero above each field
  always_comb begin
    rd_mux = '0;
    case (adr)
      REG_DLY_LOAD_LO: rd_mux = 32'(load_q[LO_W-1:0]);
      REG_DLY_LOAD_HI: rd_mux = 32'(load_q[NL-1:LO_W]);
      REG_DLY_RST_LO:  rd_mux = 32'(delay_rst_o[LO_W-1:0]);
      REG_DLY_RST_HI:  rd_mux = 32'(delay_rst_o[NL-1:LO_W]);
      REG_DLY_VTC_LO:  rd_mux = 32'(vtc_reg_o[LO_W-1:0]);
      REG_DLY_VTC_HI:  rd_mux = 32'(vtc_reg_o[NL-1:LO_W]);
      REG_DLY_VAL: begin
        rd_mux[DELAY_W-1:0] = delay_val_o;
        rd_mux[16]          = seq_busy_i;  // load sequence in progress
      end
      REG_FCLK_ERR:    rd_mux = err_cnt_i;
      REG_ISERDES_RST: rd_mux[0] = iserdes_rst_o;
      REG_MMCM_CTRL: begin
        rd_mux[24] = (G_IS_MASTER != 0);
        rd_mux[16] = mmcm_locked_i;
        rd_mux[8]  = mmcm_clksel_o;
        rd_mux[0]  = mmcm_rst_o;
      end
      REG_LCLK_CNT:    rd_mux = lclk_cnt_i;
      REG_FCLK0_CNT:   rd_mux = fclk0_cnt_i;
      REG_FCLK1_CNT:   rd_mux = fclk1_cnt_i;
      REG_FCLK2_CNT:   rd_mux = fclk2_cnt_i;
      REG_FCLK3_CNT:   rd_mux = fclk3_cnt_i;
      REG_BITSLIP:     rd_mux = 32'(bitslip_o);
      REG_SNAPSHOT:    rd_mux[0] = snapshot_trigger_o;
      REG_VERSION:     rd_mux = 32'(G_VERSION);
      REG_SLIP_IDX:    rd_mux = 32'(slip_index_o);
      default: ;  // unmapped words answer with err
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o           <= 1'b0;
      wb_err_o           <= 1'b0;
      load_req_o         <= 1'b0;
      load_q             <= '0;
      delay_rst_o        <= '0;
      vtc_reg_o          <= '1;  // vtc tracking on by default
      delay_val_o        <= '0;
      bitslip_o          <= '0;
      slip_index_o       <= '0;
      iserdes_rst_o      <= 1'b0;
      mmcm_rst_o         <= 1'b0;
      mmcm_clksel_o      <= 1'b0;
      snapshot_trigger_o <= 1'b0;
    end else begin
      wb_ack_o   <= req & ~bad;
      wb_err_o   <= req & bad;
      load_req_o <= 1'b0;  // single cycle strobe
      if (req && !bad && wb_we_i) begin
        case (adr)
          REG_DLY_LOAD_LO: begin
            load_q[LO_W-1:0] <= wdat[LO_W-1:0];
            load_req_o       <= 1'b1;
          end
          REG_DLY_LOAD_HI: begin
            load_q[NL-1:LO_W] <= wdat[HI_W-1:0];
            load_req_o        <= 1'b1;
          end
          REG_DLY_RST_LO:  delay_rst_o[LO_W-1:0]  <= wdat[LO_W-1:0];
          REG_DLY_RST_HI:  delay_rst_o[NL-1:LO_W] <= wdat[HI_W-1:0];
          REG_DLY_VTC_LO:  vtc_reg_o[LO_W-1:0]    <= wdat[LO_W-1:0];
          REG_DLY_VTC_HI:  vtc_reg_o[NL-1:LO_W]   <= wdat[HI_W-1:0];
          REG_DLY_VAL:     delay_val_o            <= wdat[DELAY_W-1:0];
          REG_ISERDES_RST: iserdes_rst_o          <= wdat[0];
          REG_MMCM_CTRL: begin
            mmcm_rst_o    <= wdat[0];
            mmcm_clksel_o <= wdat[8];
          end
          REG_BITSLIP:     bitslip_o          <= wdat[4*G_NUM_UNITS-1:0];
          REG_SNAPSHOT:    snapshot_trigger_o <= wdat[0];
          REG_SLIP_IDX:    slip_index_o       <= wdat[2:0];
          default: ;  // read only words ack without change
        endcase
      end
    end
  end

  // load lanes of the written word and read data for the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (req && !bad && wb_we_i && is_load) begin
      load_mask_o <= '0;  // only the lanes of the written word
      if (adr == REG_DLY_LOAD_LO) begin
        load_mask_o[LO_W-1:0] <= wdat[LO_W-1:0];
      end else begin
        load_mask_o[NL-1:LO_W] <= wdat[HI_W-1:0];
      end
    end
    if (req && !wb_we_i) begin
      rd_q <= rd_mux;
    end
  end

endmodule

//--- verilog/delay_load_seq.sv
module delay_load_seq
  import ads5296_pkg::*;
#(
  parameter int G_NUM_UNITS = 4,
  parameter int G_NUM_FCLKS = 1,
  parameter int G_VTC_WAIT  = 8
) (
  input  logic                                          wb_clk_i,
  input  logic                                          wb_rst_i,
  input  logic                                          load_req_i,
  input  logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] load_mask_i,
  input  logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] vtc_reg_i,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_load_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_en_vtc_o,
  output logic                                          seq_busy_o
);

  localparam int NL    = num_lanes(G_NUM_UNITS, G_NUM_FCLKS);
  localparam int CNT_W = $clog2(G_VTC_WAIT + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_VTC_OFF,  // en_vtc dropped, wait for idelay to go static
    S_LOAD,     // one cycle load pulse
    S_SETTLE    // hold en_vtc low after the load
  } state_t;

  state_t        state_q;
  logic [CNT_W-1:0] wait_q;
  logic [NL-1:0] mask_q;  // lanes of the running sequence

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= S_IDLE;
      wait_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (load_req_i) begin
            state_q <= S_VTC_OFF;
            wait_q  <= CNT_W'(G_VTC_WAIT - 1);
          end
        end
        S_VTC_OFF: begin
          if (wait_q == '0) begin
            state_q <= S_LOAD;
          end else begin
            wait_q <= wait_q - 1'b1;
          end
        end
        S_LOAD: begin
          state_q <= S_SETTLE;
          wait_q  <= CNT_W'(G_VTC_WAIT - 1);
        end
        S_SETTLE: begin
          if (wait_q == '0) begin
            state_q <= S_IDLE;  // en_vtc back to register value next cycle
          end else begin
            wait_q <= wait_q - 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // mask captured when a new sequence starts
  always_ff @(posedge wb_clk_i) begin
    if (load_req_i && state_q == S_IDLE) begin
      mask_q <= load_mask_i;
    end
  end

  assign seq_busy_o     = (state_q != S_IDLE);
  // unmasked lanes always follow the register
  assign delay_en_vtc_o = seq_busy_o ? (vtc_reg_i & ~mask_q) : vtc_reg_i;
  assign delay_load_o   = (state_q == S_LOAD) ? mask_q : '0;

endmodule

//--- verilog/frame_checker.sv
module frame_checker
  import ads5296_pkg::*;
#(
  parameter int G_NUM_FCLKS = 1
) (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic                     clr_i,
  input  logic [8*G_NUM_FCLKS-1:0] fclk_word_i,
  input  logic                     fclk_word_vld_i,
  output logic [31:0]              err_cnt_o
);

  logic [2:0]  n_bad;  // 0..4 bad lanes this cycle
  logic [32:0] sum;    // carry out flags saturation

  always_comb begin
    n_bad = '0;
    for (int i = 0; i < G_NUM_FCLKS; i++) begin
      if (fclk_word_i[8*i +: 8] != FRAME_PATTERN) begin
        n_bad = n_bad + 3'd1;
      end
    end
  end

  assign sum = {1'b0, err_cnt_o} + 33'(n_bad);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clr_i) begin
      err_cnt_o <= '0;
    end else if (fclk_word_vld_i) begin
      err_cnt_o <= sum[32] ? '1 : sum[31:0];  // stick at all ones
    end
  end

endmodule

//--- verilog/rate_counter.sv
module rate_counter
  import ads5296_pkg::*;
#(
  parameter int G_NUM_FCLKS   = 1,
  parameter int G_GATE_CYCLES = 1024
) (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   lclk_tick_i,
  input  logic [G_NUM_FCLKS-1:0] fclk_tick_i,
  output logic [31:0]            lclk_cnt_o,
  output logic [31:0]            fclk0_cnt_o,
  output logic [31:0]            fclk1_cnt_o,
  output logic [31:0]            fclk2_cnt_o,
  output logic [31:0]            fclk3_cnt_o
);

  localparam int GATE_W = $clog2(G_GATE_CYCLES);

  logic [GATE_W-1:0] gate_q;
  logic              win_end;  // last cycle of the window
  logic [4:0]        tick;     // slot 0 lclk, 1..4 fclk0..3
  logic [31:0]       run_q [5];
  logic [31:0]       lat_q [5];

  assign tick    = {4'(fclk_tick_i), lclk_tick_i};  // absent fclks never tick
  assign win_end = (gate_q == GATE_W'(G_GATE_CYCLES - 1));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      gate_q <= '0;
      for (int i = 0; i < 5; i++) begin
        run_q[i] <= '0;
        lat_q[i] <= '0;
      end
    end else begin
      gate_q <= win_end ? '0 : gate_q + 1'b1;
      for (int i = 0; i < 5; i++) begin
        if (win_end) begin
          lat_q[i] <= run_q[i] + 32'(tick[i]);  // last-cycle tick counts here
          run_q[i] <= '0;
        end else begin
          run_q[i] <= run_q[i] + 32'(tick[i]);
        end
      end
    end
  end

  assign lclk_cnt_o  = lat_q[0];
  assign fclk0_cnt_o = lat_q[1];
  assign fclk1_cnt_o = lat_q[2];
  assign fclk2_cnt_o = lat_q[3];
  assign fclk3_cnt_o = lat_q[4];

endmodule

//--- verilog/ads5296_ctrl_top.sv
module ads5296_ctrl_top
  import ads5296_pkg::*;
#(
  parameter int G_NUM_UNITS   = 4,
  parameter int G_NUM_FCLKS   = 1,
  parameter int G_IS_MASTER   = 0,
  parameter int G_VERSION     = 0,
  parameter int G_VTC_WAIT    = 8,
  parameter int G_GATE_CYCLES = 1024
) (
  input  logic                                          wb_clk_i,
  input  logic                                          wb_rst_i,
  input  logic [31:0]                                   wb_adr_i,
  input  logic [31:0]                                   wb_dat_i,
  input  logic [3:0]                                    wb_sel_i,
  input  logic                                          wb_we_i,
  input  logic                                          wb_cyc_i,
  input  logic                                          wb_stb_i,
  output logic [31:0]                                   wb_dat_o,
  output logic                                          wb_ack_o,
  output logic                                          wb_err_o,
  input  logic                                          mmcm_locked_i,
  input  logic                                          lclk_tick_i,
  input  logic [G_NUM_FCLKS-1:0]                        fclk_tick_i,
  input  logic [8*G_NUM_FCLKS-1:0]                      fclk_word_i,
  input  logic                                          fclk_word_vld_i,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_load_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_rst_o,
  output logic [num_lanes(G_NUM_UNITS, G_NUM_FCLKS)-1:0] delay_en_vtc_o,
  output logic [DELAY_W-1:0]                            delay_val_o,
  output logic [4*G_NUM_UNITS-1:0]                      bitslip_o,
  output logic [2:0]                                    slip_index_o,
  output logic                                          iserdes_rst_o,
  output logic                                          mmcm_rst_o,
  output logic                                          mmcm_clksel_o,
  output logic                                          snapshot_trigger_o
);

  localparam int NL = num_lanes(G_NUM_UNITS, G_NUM_FCLKS);

  logic          load_req;
  logic [NL-1:0] load_mask;
  logic [NL-1:0] vtc_reg;
  logic          seq_busy;
  logic [31:0]   err_cnt;
  logic [31:0]   lclk_cnt;
  logic [31:0]   fclk0_cnt;
  logic [31:0]   fclk1_cnt;
  logic [31:0]   fclk2_cnt;
  logic [31:0]   fclk3_cnt;

  wb_ads5296_attach #(
    .G_NUM_UNITS (G_NUM_UNITS),
    .G_NUM_FCLKS (G_NUM_FCLKS),
    .G_IS_MASTER (G_IS_MASTER),
    .G_VERSION   (G_VERSION)
  ) attach_i (
    .wb_clk_i           (wb_clk_i),
    .wb_rst_i           (wb_rst_i),
    .wb_adr_i           (wb_adr_i),
    .wb_dat_i           (wb_dat_i),
    .wb_sel_i           (wb_sel_i),
    .wb_we_i            (wb_we_i),
    .wb_cyc_i           (wb_cyc_i),
    .wb_stb_i           (wb_stb_i),
    .wb_dat_o           (wb_dat_o),
    .wb_ack_o           (wb_ack_o),
    .wb_err_o           (wb_err_o),
    .mmcm_locked_i      (mmcm_locked_i),
    .seq_busy_i         (seq_busy),
    .err_cnt_i          (err_cnt),
    .lclk_cnt_i         (lclk_cnt),
    .fclk0_cnt_i        (fclk0_cnt),
    .fclk1_cnt_i        (fclk1_cnt),
    .fclk2_cnt_i        (fclk2_cnt),
    .fclk3_cnt_i        (fclk3_cnt),
    .load_req_o         (load_req),
    .load_mask_o        (load_mask),
    .vtc_reg_o          (vtc_reg),
    .delay_rst_o        (delay_rst_o),
    .delay_val_o        (delay_val_o),
    .bitslip_o          (bitslip_o),
    .slip_index_o       (slip_index_o),
    .iserdes_rst_o      (iserdes_rst_o),
    .mmcm_rst_o         (mmcm_rst_o),
    .mmcm_clksel_o      (mmcm_clksel_o),
    .snapshot_trigger_o (snapshot_trigger_o)
  );

  delay_load_seq #(
    .G_NUM_UNITS (G_NUM_UNITS),
    .G_NUM_FCLKS (G_NUM_FCLKS),
    .G_VTC_WAIT  (G_VTC_WAIT)
  ) seq_i (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .load_req_i     (load_req),
    .load_mask_i    (load_mask),
    .vtc_reg_i      (vtc_reg),
    .delay_load_o   (delay_load_o),
    .delay_en_vtc_o (delay_en_vtc_o),
    .seq_busy_o     (seq_busy)
  );

  // error count held at zero while the iserdes is in reset
  frame_checker #(
    .G_NUM_FCLKS (G_NUM_FCLKS)
  ) fchk_i (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .clr_i           (iserdes_rst_o),
    .fclk_word_i     (fclk_word_i),
    .fclk_word_vld_i (fclk_word_vld_i),
    .err_cnt_o       (err_cnt)
  );

  rate_counter #(
    .G_NUM_FCLKS   (G_NUM_FCLKS),
    .G_GATE_CYCLES (G_GATE_CYCLES)
  ) rate_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .lclk_tick_i (lclk_tick_i),
    .fclk_tick_i (fclk_tick_i),
    .lclk_cnt_o  (lclk_cnt),
    .fclk0_cnt_o (fclk0_cnt),
    .fclk1_cnt_o (fclk1_cnt),
    .fclk2_cnt_o (fclk2_cnt),
    .fclk3_cnt_o (fclk3_cnt)
  );

endmodule

//--- tb/tb_ads5296_ctrl.sv
module tb_ads5296_ctrl
  import ads5296_pkg::*;
();

  localparam int NL         = num_lanes(4, 2);  // 35 lanes
  localparam int LO_W       = 32;
  localparam int GATE       = 64;
  localparam int TB_VERSION = 32'h0005_2960;

  logic              wb_clk_i, wb_rst_i;
  logic [31:0]       wb_adr_i, wb_dat_i, wb_dat_o;
  logic [3:0]        wb_sel_i;
  logic              wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o, wb_err_o;
  logic              mmcm_locked_i, lclk_tick_i, fclk_word_vld_i;
  logic [1:0]        fclk_tick_i;
  logic [15:0]       fclk_word_i;
  logic [NL-1:0]     delay_load_o, delay_rst_o, delay_en_vtc_o;
  logic [DELAY_W-1:0] delay_val_o;
  logic [15:0]       bitslip_o;
  logic [2:0]        slip_index_o;
  logic              iserdes_rst_o, mmcm_rst_o, mmcm_clksel_o, snapshot_trigger_o;

  // register model
  logic [NL-1:0]     m_load, m_rst, m_vtc;
  logic [8:0]        m_val;
  logic [15:0]       m_bslip;
  logic [2:0]        m_slip;
  logic              m_iser, m_mrst, m_clksel, m_snap;
  logic [31:0]       m_err;
  logic [31:0]       m_run [3];  // lclk, fclk0, fclk1
  logic [31:0]       m_lat [3];
  int                gate_pos;   // own copy of the window position
  logic [31:0]       seed = 59;
  int                n_err = 0;
  int                n_fail = 0;
  logic [4:0]        wr_words [10] = '{5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd8, 5'd9, 5'd15,
                                        5'd16, 5'd18};

  ads5296_ctrl_top #(
    .G_NUM_UNITS (4), .G_NUM_FCLKS (2), .G_IS_MASTER (1), .G_VERSION (TB_VERSION),
    .G_VTC_WAIT (8), .G_GATE_CYCLES (GATE)
  ) dut_i (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i), .wb_we_i (wb_we_i), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o),
    .mmcm_locked_i (mmcm_locked_i), .lclk_tick_i (lclk_tick_i), .fclk_tick_i (fclk_tick_i),
    .fclk_word_i (fclk_word_i), .fclk_word_vld_i (fclk_word_vld_i),
    .delay_load_o (delay_load_o), .delay_rst_o (delay_rst_o),
    .delay_en_vtc_o (delay_en_vtc_o), .delay_val_o (delay_val_o), .bitslip_o (bitslip_o),
    .slip_index_o (slip_index_o), .iserdes_rst_o (iserdes_rst_o), .mmcm_rst_o (mmcm_rst_o),
    .mmcm_clksel_o (mmcm_clksel_o), .snapshot_trigger_o (snapshot_trigger_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  // gate timer restarts with reset, then wraps every GATE cycles
  always @(posedge wb_clk_i) begin
    if (wb_rst_i) gate_pos <= 0;
    else gate_pos <= (gate_pos == GATE - 1) ? 0 : gate_pos + 1;
  end

  // two lcg steps, upper halves only
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    seed = seed * 32'd1664525 + 32'd1013904223;
    hi   = seed[31:16];
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {hi, seed[31:16]};
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      n_err++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic model_write(input logic [4:0] w, input logic [31:0] d);
    case (w)
      REG_DLY_LOAD_LO: m_load[LO_W-1:0]  = d;
      REG_DLY_LOAD_HI: m_load[NL-1:LO_W] = d[2:0];
      REG_DLY_RST_LO:  m_rst[LO_W-1:0]   = d;
      REG_DLY_RST_HI:  m_rst[NL-1:LO_W]  = d[2:0];
      REG_DLY_VTC_LO:  m_vtc[LO_W-1:0]   = d;
      REG_DLY_VTC_HI:  m_vtc[NL-1:LO_W]  = d[2:0];
      REG_DLY_VAL:     m_val             = d[8:0];
      REG_ISERDES_RST: begin
        m_iser = d[0];
        if (d[0]) m_err = 0;  // checker held clear
      end
      REG_MMCM_CTRL: begin
        m_mrst   = d[0];
        m_clksel = d[8];
      end
      REG_BITSLIP:     m_bslip = d[15:0];
      REG_SNAPSHOT:    m_snap  = d[0];
      REG_SLIP_IDX:    m_slip  = d[2:0];
      default: ;
    endcase
  endtask

  // expected read data with the sequencer idle
  function automatic logic [31:0] model_read(input logic [4:0] w);
    logic [31:0] r;
    r = '0;
    case (w)
      REG_DLY_LOAD_LO: r = m_load[LO_W-1:0];
      REG_DLY_LOAD_HI: r[2:0] = m_load[NL-1:LO_W];
      REG_DLY_RST_LO:  r = m_rst[LO_W-1:0];
      REG_DLY_RST_HI:  r[2:0] = m_rst[NL-1:LO_W];
      REG_DLY_VTC_LO:  r = m_vtc[LO_W-1:0];
      REG_DLY_VTC_HI:  r[2:0] = m_vtc[NL-1:LO_W];
      REG_DLY_VAL:     r[8:0] = m_val;
      REG_FCLK_ERR:    r = m_err;
      REG_ISERDES_RST: r[0] = m_iser;
      REG_MMCM_CTRL:   r = {7'd0, 1'b1, 7'd0, mmcm_locked_i, 7'd0, m_clksel, 7'd0, m_mrst};
      REG_LCLK_CNT:    r = m_lat[0];
      REG_FCLK0_CNT:   r = m_lat[1];
      REG_FCLK1_CNT:   r = m_lat[2];
      REG_BITSLIP:     r[15:0] = m_bslip;
      REG_SNAPSHOT:    r[0] = m_snap;
      REG_VERSION:     r = TB_VERSION;
      REG_SLIP_IDX:    r[2:0] = m_slip;
      default: ;  // fclk2/3 slots unused
    endcase
    return r;
  endfunction

  // one classic cycle, called on a falling edge, returns on the response edge
  task automatic wb_xfer(input logic we, input logic [4:0] w, input logic [31:0] d,
                         output logic [31:0] rd, output logic got_err);
    int t;
    t = 0;
    if (wb_ack_o || wb_err_o) begin
      @(negedge wb_clk_i);  // stb stays low through the previous response
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {25'd0, w, 2'b00};
    wb_dat_i = d;
    wb_sel_i = 4'hF;
    @(negedge wb_clk_i);
    while (!wb_ack_o && !wb_err_o && t < 20) begin
      @(negedge wb_clk_i);
      t++;
    end
    if (!wb_ack_o && !wb_err_o) begin
      n_fail++;
      $display("timeout: no ack or err for word %0d", w);
    end
    compare("response latency", t, 0);
    rd       = wb_dat_o;
    got_err  = wb_err_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic check_outputs();
    compare("delay_rst_o", delay_rst_o, m_rst);
    compare("delay_en_vtc_o", delay_en_vtc_o, m_vtc);  // sequencer idle here
    compare("delay_load_o", delay_load_o, '0);
    compare("delay_val_o", delay_val_o, m_val);
    compare("bitslip_o", bitslip_o, m_bslip);
    compare("slip_index_o", slip_index_o, m_slip);
    compare("iserdes_rst_o", iserdes_rst_o, m_iser);
    compare("mmcm_rst_o", mmcm_rst_o, m_mrst);
    compare("mmcm_clksel_o", mmcm_clksel_o, m_clksel);
    compare("snapshot_trigger_o", snapshot_trigger_o, m_snap);
  endtask

  task automatic write_word(input logic [4:0] w, input logic [31:0] d);
    logic [31:0] rd;
    logic        e;
    wb_xfer(1'b1, w, d, rd, e);
    if (e) begin
      n_fail++;
      $display("write to word %0d was refused with err", w);
    end else begin
      model_write(w, d);
    end
    check_outputs();
  endtask

  task automatic read_check(input logic [4:0] w, input logic [31:0] exp);
    logic [31:0] rd;
    logic        e;
    wb_xfer(1'b0, w, 32'd0, rd, e);
    if (e) begin
      n_fail++;
      $display("read of word %0d was refused with err", w);
    end
    compare($sformatf("wb_dat_o word %0d", w), rd, exp);
  endtask

  task automatic load_seq_test();
    logic [31:0] mask, rd;
    logic [NL-1:0] lanes;
    logic        e, busy_seen;
    int          t;
    mask  = next_rand();
    lanes = NL'(mask);
    wb_xfer(1'b1, REG_DLY_LOAD_LO, mask, rd, e);  // returns in cycle 0
    if (e) begin
      n_fail++;
      $display("load write was refused with err while idle");
    end
    model_write(REG_DLY_LOAD_LO, mask);
    for (int k = 0; k <= 20; k++) begin
      if (k > 0) @(negedge wb_clk_i);
      compare($sformatf("delay_en_vtc_o cycle %0d", k), delay_en_vtc_o,
              (k >= 1 && k <= 17) ? (m_vtc & ~lanes) : m_vtc);
      compare($sformatf("delay_load_o cycle %0d", k), delay_load_o, (k == 9) ? lanes : '0);
    end
    mask = next_rand();
    write_word(REG_DLY_LOAD_LO, mask);
    wb_xfer(1'b1, REG_DLY_LOAD_HI, 32'h7, rd, e);  // sequencer now busy
    if (!e) begin
      n_fail++;
      $display("load write while busy was acked instead of refused");
    end
    busy_seen = 1'b0;
    t = 0;
    rd = 32'h1_0000;
    while (rd[16] && t < 100) begin
      wb_xfer(1'b0, REG_DLY_VAL, 32'd0, rd, e);
      busy_seen |= rd[16];
      t++;
    end
    if (rd[16]) begin
      n_fail++;
      $display("timeout: sequencer busy flag never cleared");
    end
    if (!busy_seen) begin
      n_fail++;
      $display("busy flag was never seen during the load sequence");
    end
    read_check(REG_DLY_LOAD_HI, model_read(REG_DLY_LOAD_HI));  // refused write left it
    read_check(REG_DLY_LOAD_LO, model_read(REG_DLY_LOAD_LO));
    check_outputs();
  endtask

  task automatic frame_test();
    logic [31:0] r;
    write_word(REG_ISERDES_RST, 32'd0);
    repeat (200) begin
      r = next_rand();
      fclk_word_vld_i  = r[4];
      fclk_word_i[7:0]  = r[8] ? FRAME_PATTERN : r[23:16];  // correct or corrupted
      fclk_word_i[15:8] = r[9] ? FRAME_PATTERN : r[31:24];
      if (r[4]) begin
        m_err += 32'(fclk_word_i[7:0] != FRAME_PATTERN);
        m_err += 32'(fclk_word_i[15:8] != FRAME_PATTERN);
      end
      @(negedge wb_clk_i);
    end
    fclk_word_vld_i = 1'b0;
    read_check(REG_FCLK_ERR, m_err);
    write_word(REG_ISERDES_RST, 32'd1);
    read_check(REG_FCLK_ERR, 32'd0);
    write_word(REG_ISERDES_RST, 32'd0);
    read_check(REG_FCLK_ERR, 32'd0);
  endtask

  task automatic rate_test();
    logic [31:0] r;
    int          ends, t;
    ends = 0;
    t    = 0;
    while (ends < 3 && t < 1000) begin
      r = next_rand();
      lclk_tick_i = r[0];
      fclk_tick_i = r[2:1];
      for (int i = 0; i < 3; i++) m_run[i] += 32'(r[i]);
      if (gate_pos == GATE - 1) begin  // this cycle closes the window
        for (int i = 0; i < 3; i++) begin
          m_lat[i] = m_run[i];
          m_run[i] = 0;
        end
        ends++;
      end
      @(negedge wb_clk_i);
      t++;
    end
    lclk_tick_i = 1'b0;
    fclk_tick_i = 2'b00;
    if (ends < 3) begin
      n_fail++;
      $display("timeout: rate window end not reached");
    end
    for (int w = 10; w <= 14; w++) read_check(5'(w), model_read(5'(w)));
  endtask

  initial begin
    logic [31:0] r, rd;
    logic        e;
    wb_rst_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    mmcm_locked_i   = 1'b0;
    lclk_tick_i     = 1'b0;
    fclk_tick_i     = '0;
    fclk_word_i     = {2{FRAME_PATTERN}};
    fclk_word_vld_i = 1'b0;
    m_load = '0;
    m_rst  = '0;
    m_vtc  = '1;
    m_val  = '0;
    m_bslip = '0;
    m_slip = '0;
    {m_iser, m_mrst, m_clksel, m_snap} = '0;
    m_err = '0;
    for (int i = 0; i < 3; i++) begin
      m_run[i] = '0;
      m_lat[i] = '0;
    end
    repeat (10) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    check_outputs();  // reset values
    compare("wb_ack_o", wb_ack_o, 1'b0);
    compare("wb_err_o", wb_err_o, 1'b0);
    repeat (40) write_word(wr_words[next_rand() % 10], next_rand());
    for (int w = 0; w <= 18; w++) read_check(5'(w), model_read(5'(w)));
    repeat (4) begin
      r = next_rand();
      mmcm_locked_i = r[0];
      write_word(REG_MMCM_CTRL, next_rand());
      read_check(REG_MMCM_CTRL, model_read(REG_MMCM_CTRL));
      read_check(REG_VERSION, TB_VERSION);
      wb_xfer(r[1], 5'(19 + next_rand() % 13), next_rand(), rd, e);  // unmapped word
      if (!e) begin
        n_fail++;
        $display("unmapped access was not answered with err");
      end
      compare("wb_dat_o on err", rd, 32'd0);
      check_outputs();
    end
    load_seq_test();
    frame_test();
    rate_test();
    $display("checks done: %0d mismatches, %0d other failures", n_err, n_fail);
    if (n_err == 0 && n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/ads5296_pkg.sv
verilog/wb_ads5296_attach.sv
verilog/delay_load_seq.sv
verilog/frame_checker.sv
verilog/rate_counter.sv
verilog/ads5296_ctrl_top.sv
tb/tb_ads5296_ctrl.sv
